//--- hw/core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the RV32I decode stage
// Only the base integer opcodes are listed. Compressed forms are not
// decoded, so bits [1:0] must be 2'b11 for a valid opcode
// gen_imm returns a sign-extended immediate, except CSR (zero-extended)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package core_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [31:0] rdata_t;
  typedef logic [4:0]  raddr_t;
  typedef logic [31:0] instr_raw_t;

  typedef enum logic [6:0] {
    RV_LUI      = 7'b0110111,
    RV_AUIPC    = 7'b0010111,
    RV_JAL      = 7'b1101111,
    RV_JALR     = 7'b1100111,
    RV_BRANCH   = 7'b1100011,
    RV_LOAD     = 7'b0000011,
    RV_STORE    = 7'b0100011,
    RV_OP_IMM   = 7'b0010011,
    RV_OP       = 7'b0110011,
    RV_MISC_MEM = 7'b0001111,
    RV_SYSTEM   = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    RV_F3_ADD_SUB = 3'b000,
    RV_F3_SLL     = 3'b001,
    RV_F3_SLT     = 3'b010,
    RV_F3_SLTU    = 3'b011,
    RV_F3_XOR     = 3'b100,
    RV_F3_SRL_SRA = 3'b101,
    RV_F3_OR      = 3'b110,
    RV_F3_AND     = 3'b111
  } f3_t;

  typedef enum logic [6:0] {
    RV_F7_0 = 7'b0000000,
    RV_F7_1 = 7'b0100000
  } f7_t;

  typedef enum logic {
    RV_SRL = 1'b0,
    RV_SRA = 1'b1
  } shift_t;

  typedef enum logic [2:0] {
    I_IMM,
    S_IMM,
    B_IMM,
    U_IMM,
    J_IMM,
    CSR_IMM
  } imm_type_t;

  typedef enum logic [1:0] {
    ZERO,
    REG_RF,
    IMM,
    PC
  } op_sel_t;

  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LOAD,
    LSU_STORE
  } lsu_t;

  // Load/store width, same coding as funct3
  typedef enum logic [2:0] {
    RV_LSU_B  = 3'b000,
    RV_LSU_H  = 3'b001,
    RV_LSU_W  = 3'b010,
    RV_LSU_BU = 3'b100,
    RV_LSU_HU = 3'b101
  } lsu_w_t;

  typedef enum logic [2:0] {
    RV_CSR_NONE = 3'b000,
    RV_CSRRW    = 3'b001,
    RV_CSRRS    = 3'b010,
    RV_CSRRC    = 3'b011,
    RV_CSRRWI   = 3'b101,
    RV_CSRRSI   = 3'b110,
    RV_CSRRCI   = 3'b111
  } csr_t;

  typedef struct packed {
    logic [6:0] f7;
    raddr_t     rs2;
    raddr_t     rs1;
    logic [2:0] f3;
    raddr_t     rd;
    opcode_t    op;
  } s_instr_t;

  typedef struct packed {
    csr_t        op;
    logic [11:0] addr;
  } s_csr_t;

  // All zeros is a NOP
  typedef struct packed {
    pc_t     pc_dec;
    raddr_t  rd_addr;
    raddr_t  rs1_addr;
    raddr_t  rs2_addr;
    f3_t     f3;
    f7_t     f7;
    shift_t  rshift;
    op_sel_t rs1_op;
    op_sel_t rs2_op;
    rdata_t  imm;
    logic    we_rd;
    logic    jump;
    logic    branch;
    lsu_t    lsu;
    lsu_w_t  lsu_w;
    s_csr_t  csr;
    logic    ecall;
    logic    ebreak;
    logic    mret;
    logic    wfi;
  } s_id_ex_t;

  typedef struct packed {
    raddr_t rd_addr;
    rdata_t rd_data;
    logic   we_rd;
  } s_wb_t;

  typedef struct packed {
    logic active;
    pc_t  pc_addr;
  } s_trap_info_t;

  function automatic rdata_t gen_imm(instr_raw_t instr, imm_type_t imm_type);
    rdata_t imm;
    case (imm_type)
      I_IMM:   imm = {{20{instr[31]}}, instr[31:20]};
      S_IMM:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      B_IMM:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      U_IMM:   imm = {instr[31:12], 12'h000};
      J_IMM:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      // zimm field sits in the rs1 slot
      CSR_IMM: imm = {27'd0, instr[19:15]};
      default: imm = '0;
    endcase
    return imm;
  endfunction

endpackage

//--- hw/instr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational RV32I field decode, pc_dec is left at zero
// Unsupported encodings raise illegal_o and give an all-zero bundle
// With SUPPORT_DEBUG at 0, EBREAK counts as unsupported
// Load/store funct3 is passed through without a width check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decoder #(
  parameter int SUPPORT_DEBUG = 1
) (
  input  core_pkg::instr_raw_t instr_i,
  output core_pkg::s_id_ex_t   id_ex_o,
  output logic                 illegal_o
);
  core_pkg::s_instr_t instr;

  assign instr = core_pkg::s_instr_t'(instr_i);

  always_comb begin
    id_ex_o          = core_pkg::s_id_ex_t'('0);
    illegal_o        = 1'b0;
    id_ex_o.rd_addr  = instr.rd;
    id_ex_o.rs1_addr = instr.rs1;
    id_ex_o.rs2_addr = instr.rs2;

    case (instr.op)
      core_pkg::RV_OP_IMM: begin
        id_ex_o.f3     = core_pkg::f3_t'(instr.f3);
        id_ex_o.rs1_op = core_pkg::REG_RF;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::I_IMM);
        id_ex_o.rshift = instr_i[30] ? core_pkg::RV_SRA : core_pkg::RV_SRL;
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_LUI: begin
        id_ex_o.rs1_op = core_pkg::ZERO;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::U_IMM);
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_AUIPC: begin
        id_ex_o.rs1_op = core_pkg::PC;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::U_IMM);
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_OP: begin
        id_ex_o.f3     = core_pkg::f3_t'(instr.f3);
        id_ex_o.f7     = instr_i[30] ? core_pkg::RV_F7_1 : core_pkg::RV_F7_0;
        id_ex_o.rshift = instr_i[30] ? core_pkg::RV_SRA : core_pkg::RV_SRL;
        id_ex_o.rs1_op = core_pkg::REG_RF;
        id_ex_o.rs2_op = core_pkg::REG_RF;
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_JAL: begin
        id_ex_o.jump   = 1'b1;
        id_ex_o.rs1_op = core_pkg::PC;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::J_IMM);
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_JALR: begin
        id_ex_o.jump   = 1'b1;
        id_ex_o.rs1_op = core_pkg::REG_RF;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::I_IMM);
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_BRANCH: begin
        id_ex_o.branch = 1'b1;
        id_ex_o.f3     = core_pkg::f3_t'(instr.f3);
        id_ex_o.rs1_op = core_pkg::REG_RF;
        id_ex_o.rs2_op = core_pkg::REG_RF;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::B_IMM);
      end
      core_pkg::RV_LOAD: begin
        id_ex_o.lsu    = core_pkg::LSU_LOAD;
        id_ex_o.lsu_w  = core_pkg::lsu_w_t'(instr.f3);
        id_ex_o.rs1_op = core_pkg::REG_RF;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::I_IMM);
        id_ex_o.we_rd  = 1'b1;
      end
      core_pkg::RV_STORE: begin
        // Address from rs1 + imm, store data comes from rs2 read port
        id_ex_o.lsu    = core_pkg::LSU_STORE;
        id_ex_o.lsu_w  = core_pkg::lsu_w_t'(instr.f3);
        id_ex_o.rs1_op = core_pkg::REG_RF;
        id_ex_o.rs2_op = core_pkg::IMM;
        id_ex_o.imm    = core_pkg::gen_imm(instr_i, core_pkg::S_IMM);
      end
      core_pkg::RV_MISC_MEM: begin
        // Fence is a no-op for an in-order core
        id_ex_o.rs1_op = core_pkg::ZERO;
        id_ex_o.rs2_op = core_pkg::ZERO;
      end
      core_pkg::RV_SYSTEM: begin
        if ((instr.f3 != 3'b000) && (instr.f3 != 3'b100)) begin
          id_ex_o.rs1_op   = instr.f3[2] ? core_pkg::IMM : core_pkg::REG_RF;
          id_ex_o.imm      = core_pkg::gen_imm(instr_i, core_pkg::CSR_IMM);
          id_ex_o.csr.op   = core_pkg::csr_t'(instr.f3);
          id_ex_o.csr.addr = instr_i[31:20];
          id_ex_o.we_rd    = (instr.rd != 5'd0);
        end else if ((instr.f3 == 3'b000) && (instr.rd == 5'd0) && (instr.rs1 == 5'd0)) begin
          if ((instr.f7 == 7'h00) && (instr.rs2 == 5'd0)) begin
            id_ex_o.ecall = 1'b1;
          end else if ((instr.f7 == 7'h00) && (instr.rs2 == 5'd1) && (SUPPORT_DEBUG != 0)) begin
            id_ex_o.ebreak = 1'b1;
          end else if ((instr.f7 == 7'h18) && (instr.rs2 == 5'd2)) begin
            id_ex_o.mret = 1'b1;
          end else if ((instr.f7 == 7'h08) && (instr.rs2 == 5'd5)) begin
            id_ex_o.wfi = 1'b1;
          end else begin
            illegal_o = 1'b1;
          end
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase

    // Unsupported goes down the pipe as a NOP
    if (illegal_o) begin
      id_ex_o = core_pkg::s_id_ex_t'('0);
    end
  end

endmodule

//--- hw/register_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32-bit integer registers, x0 reads as zero
// Reads are registered and only update while re_i is high
// No write-to-read bypass, a same-edge write returns the old value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              rst_i,
  input  core_pkg::raddr_t  rs1_addr_i,
  input  core_pkg::raddr_t  rs2_addr_i,
  input  logic              re_i,
  input  core_pkg::s_wb_t   wb_i,
  output core_pkg::rdata_t  rs1_data_o,
  output core_pkg::rdata_t  rs2_data_o
);
  // x0 has no storage
  core_pkg::rdata_t regs_ff [31:1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_ff[i] <= '0;
      end
      rs1_data_o <= '0;
      rs2_data_o <= '0;
    end else begin
      if (wb_i.we_rd && (wb_i.rd_addr != 5'd0)) begin
        regs_ff[wb_i.rd_addr] <= wb_i.rd_data;
      end
      if (re_i) begin
        rs1_data_o <= (rs1_addr_i == 5'd0) ? '0 : regs_ff[rs1_addr_i];
        rs2_data_o <= (rs2_addr_i == 5'd0) ? '0 : regs_ff[rs2_addr_i];
      end
    end
  end

endmodule

//--- hw/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage control, one instruction in flight, no skid buffer
// fetch_ready_o is id_ready_i, so back-pressure reaches fetch at once
// A jump loads the next PC from pc_jump_i. An instruction accepted in
// the jump cycle itself is wrong-path and keeps the old sequence PC
// trap_info_o is combinational in the acceptance cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage #(
  parameter core_pkg::pc_t RESET_PC      = '0,
  parameter int            SUPPORT_DEBUG = 1
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   jump_i,
  input  core_pkg::pc_t          pc_jump_i,
  input  logic                   fetch_valid_i,
  input  core_pkg::instr_raw_t   fetch_instr_i,
  output logic                   fetch_ready_o,
  input  core_pkg::s_wb_t        wb_dec_i,
  output core_pkg::s_id_ex_t     id_ex_o,
  output core_pkg::rdata_t       rs1_data_o,
  output core_pkg::rdata_t       rs2_data_o,
  output logic                   id_valid_o,
  input  logic                   id_ready_i,
  output core_pkg::s_trap_info_t trap_info_o
);
  core_pkg::s_instr_t instr;
  core_pkg::s_id_ex_t dec_bundle;
  core_pkg::s_id_ex_t next_id_ex;
  core_pkg::s_id_ex_t id_ex_ff;
  core_pkg::pc_t      pc_ff;
  core_pkg::pc_t      pc_cur;
  logic               illegal;
  logic               accept;
  logic               started_ff;
  logic               valid_ff;

  assign instr         = core_pkg::s_instr_t'(fetch_instr_i);
  assign accept        = fetch_valid_i && id_ready_i;
  assign fetch_ready_o = id_ready_i;
  assign id_valid_o    = valid_ff;

  // First instruction after reset or jump takes the base PC as is
  assign pc_cur = started_ff ? (pc_ff + 32'd4) : pc_ff;

  // Flushed slot becomes a NOP
  assign id_ex_o = jump_i ? core_pkg::s_id_ex_t'('0) : id_ex_ff;

  instr_decoder #(
    .SUPPORT_DEBUG (SUPPORT_DEBUG)
  ) u_instr_decoder (
    .instr_i   (fetch_instr_i),
    .id_ex_o   (dec_bundle),
    .illegal_o (illegal)
  );

  register_file u_register_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (instr.rs1),
    .rs2_addr_i (instr.rs2),
    .re_i       (id_ready_i),
    .wb_i       (wb_dec_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o)
  );

  always_comb begin
    next_id_ex        = dec_bundle;
    next_id_ex.pc_dec = pc_cur;
  end

  always_comb begin
    trap_info_o = core_pkg::s_trap_info_t'('0);
    if (accept && illegal) begin
      trap_info_o.active  = 1'b1;
      trap_info_o.pc_addr = pc_cur;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_ff        <= 1'b0;
      id_ex_ff        <= core_pkg::s_id_ex_t'('0);
      id_ex_ff.pc_dec <= RESET_PC;
      pc_ff           <= RESET_PC;
      started_ff      <= 1'b0;
    end else begin
      // Everything holds while execute stalls
      if (id_ready_i) begin
        valid_ff <= fetch_valid_i;
        id_ex_ff <= next_id_ex;
      end
      if (jump_i) begin
        pc_ff      <= pc_jump_i;
        started_ff <= 1'b0;
      end else if (accept) begin
        pc_ff      <= pc_cur;
        started_ff <= 1'b1;
      end
    end
  end

endmodule

//--- hw/decode_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode top level, sets the start PC and debug support
// Writeback, execute and trap ports go straight to the decode stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_top #(
  parameter core_pkg::pc_t RESET_PC      = 32'h0000_0000,
  parameter int            SUPPORT_DEBUG = 1
) (
  input  logic                   clk,
  input  logic                   rst_i,
  // Redirect from execute
  input  logic                   jump_i,
  input  core_pkg::pc_t          pc_jump_i,
  // Fetch side
  input  logic                   fetch_valid_i,
  input  core_pkg::instr_raw_t   fetch_instr_i,
  output logic                   fetch_ready_o,
  input  core_pkg::s_wb_t        wb_dec_i,
  // Execute side
  output core_pkg::s_id_ex_t     id_ex_o,
  output core_pkg::rdata_t       rs1_data_o,
  output core_pkg::rdata_t       rs2_data_o,
  output logic                   id_valid_o,
  input  logic                   id_ready_i,
  output core_pkg::s_trap_info_t trap_info_o
);

  decode_stage #(
    .RESET_PC      (RESET_PC),
    .SUPPORT_DEBUG (SUPPORT_DEBUG)
  ) u_decode_stage (
    .clk           (clk),
    .rst_i         (rst_i),
    .jump_i        (jump_i),
    .pc_jump_i     (pc_jump_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .wb_dec_i      (wb_dec_i),
    .id_ex_o       (id_ex_o),
    .rs1_data_o    (rs1_data_o),
    .rs2_data_o    (rs2_data_o),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i),
    .trap_info_o   (trap_info_o)
  );

endmodule

//--- tb/decode_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for decode_top, driven on the falling edge
// Random stimulus from one fixed seed, checked against a model here
// Jump pulses are sent with fetch_valid_i low
// Model assumes SUPPORT_DEBUG at 1, so EBREAK is legal
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_tb;
  localparam core_pkg::pc_t RESET_PC      = 32'h0000_0100;
  localparam int            SUPPORT_DEBUG = 1;
  localparam int            TIMEOUT       = 20;

  logic                   clk = 1'b0;
  logic                   rst_i;
  logic                   jump_i;
  core_pkg::pc_t          pc_jump_i;
  logic                   fetch_valid_i;
  core_pkg::instr_raw_t   fetch_instr_i;
  logic                   fetch_ready_o;
  core_pkg::s_wb_t        wb_dec_i;
  core_pkg::s_id_ex_t     id_ex_o;
  core_pkg::rdata_t       rs1_data_o;
  core_pkg::rdata_t       rs2_data_o;
  logic                   id_valid_o;
  logic                   id_ready_i;
  core_pkg::s_trap_info_t trap_info_o;

  // Model state
  core_pkg::rdata_t   regs [32];
  core_pkg::pc_t      exp_pc;
  core_pkg::s_id_ex_t exp_bundle;
  core_pkg::rdata_t   exp_rs1;
  core_pkg::rdata_t   exp_rs2;
  logic               exp_valid;

  int err_cnt;
  int err_mark;
  int tests_ok;
  int tests_bad;

  decode_top #(
    .RESET_PC      (RESET_PC),
    .SUPPORT_DEBUG (SUPPORT_DEBUG)
  ) dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .jump_i        (jump_i),
    .pc_jump_i     (pc_jump_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .wb_dec_i      (wb_dec_i),
    .id_ex_o       (id_ex_o),
    .rs1_data_o    (rs1_data_o),
    .rs2_data_o    (rs2_data_o),
    .id_valid_o    (id_valid_o),
    .id_ready_i    (id_ready_i),
    .trap_info_o   (trap_info_o)
  );

  always #50 clk = ~clk;

  task automatic check_val(input string name, input logic [127:0] exp_v,
                           input logic [127:0] act_v);
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("ERR %s expected %h got %h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic check_bundle(input core_pkg::s_id_ex_t e, input core_pkg::s_id_ex_t a);
    check_val("id_ex_o.pc_dec", 128'(e.pc_dec), 128'(a.pc_dec));
    check_val("id_ex_o.rd_addr", 128'(e.rd_addr), 128'(a.rd_addr));
    check_val("id_ex_o.rs1_addr", 128'(e.rs1_addr), 128'(a.rs1_addr));
    check_val("id_ex_o.rs2_addr", 128'(e.rs2_addr), 128'(a.rs2_addr));
    check_val("id_ex_o.f3", 128'(e.f3), 128'(a.f3));
    check_val("id_ex_o.f7", 128'(e.f7), 128'(a.f7));
    check_val("id_ex_o.rshift", 128'(e.rshift), 128'(a.rshift));
    check_val("id_ex_o.rs1_op", 128'(e.rs1_op), 128'(a.rs1_op));
    check_val("id_ex_o.rs2_op", 128'(e.rs2_op), 128'(a.rs2_op));
    check_val("id_ex_o.imm", 128'(e.imm), 128'(a.imm));
    check_val("id_ex_o.we_rd", 128'(e.we_rd), 128'(a.we_rd));
    check_val("id_ex_o.jump", 128'(e.jump), 128'(a.jump));
    check_val("id_ex_o.branch", 128'(e.branch), 128'(a.branch));
    check_val("id_ex_o.lsu", 128'(e.lsu), 128'(a.lsu));
    check_val("id_ex_o.lsu_w", 128'(e.lsu_w), 128'(a.lsu_w));
    check_val("id_ex_o.csr", 128'(e.csr), 128'(a.csr));
    check_val("id_ex_o.sys", 128'({e.ecall, e.ebreak, e.mret, e.wfi}),
              128'({a.ecall, a.ebreak, a.mret, a.wfi}));
  endtask

  // Expected bundle for one raw instruction, straight from the ISA tables
  function automatic core_pkg::s_id_ex_t model_decode(input core_pkg::instr_raw_t w,
                                                      input core_pkg::pc_t pc,
                                                      output logic ill);
    core_pkg::s_id_ex_t  b;
    core_pkg::op_sel_t   s1;
    core_pkg::op_sel_t   s2;
    core_pkg::imm_type_t it;
    logic                use_imm;
    b = '0;
    s1 = core_pkg::ZERO;
    s2 = core_pkg::ZERO;
    it = core_pkg::I_IMM;
    use_imm = 1'b0;
    ill = 1'b0;
    b.rd_addr = w[11:7];
    b.rs1_addr = w[19:15];
    b.rs2_addr = w[24:20];
    case (w[6:0])
      core_pkg::RV_OP_IMM: begin
        b.f3 = core_pkg::f3_t'(w[14:12]);
        b.rshift = core_pkg::shift_t'(w[30]);
        s1 = core_pkg::REG_RF;
        s2 = core_pkg::IMM;
        use_imm = 1'b1;
        b.we_rd = 1'b1;
      end
      core_pkg::RV_LUI, core_pkg::RV_AUIPC: begin
        s1 = (w[5] == 1'b1) ? core_pkg::ZERO : core_pkg::PC;
        s2 = core_pkg::IMM;
        it = core_pkg::U_IMM;
        use_imm = 1'b1;
        b.we_rd = 1'b1;
      end
      core_pkg::RV_OP: begin
        b.f3 = core_pkg::f3_t'(w[14:12]);
        b.f7 = core_pkg::f7_t'({1'b0, w[30], 5'b00000});
        b.rshift = core_pkg::shift_t'(w[30]);
        s1 = core_pkg::REG_RF;
        s2 = core_pkg::REG_RF;
        b.we_rd = 1'b1;
      end
      core_pkg::RV_JAL, core_pkg::RV_JALR: begin
        b.jump = 1'b1;
        s1 = (w[3] == 1'b1) ? core_pkg::PC : core_pkg::REG_RF;
        s2 = core_pkg::IMM;
        it = (w[3] == 1'b1) ? core_pkg::J_IMM : core_pkg::I_IMM;
        use_imm = 1'b1;
        b.we_rd = 1'b1;
      end
      core_pkg::RV_BRANCH: begin
        b.branch = 1'b1;
        b.f3 = core_pkg::f3_t'(w[14:12]);
        s1 = core_pkg::REG_RF;
        s2 = core_pkg::REG_RF;
        it = core_pkg::B_IMM;
        use_imm = 1'b1;
      end
      core_pkg::RV_LOAD, core_pkg::RV_STORE: begin
        b.lsu = (w[5] == 1'b1) ? core_pkg::LSU_STORE : core_pkg::LSU_LOAD;
        b.lsu_w = core_pkg::lsu_w_t'(w[14:12]);
        s1 = core_pkg::REG_RF;
        s2 = core_pkg::IMM;
        it = (w[5] == 1'b1) ? core_pkg::S_IMM : core_pkg::I_IMM;
        use_imm = 1'b1;
        b.we_rd = ~w[5];
      end
      core_pkg::RV_MISC_MEM: begin
        use_imm = 1'b0;
      end
      core_pkg::RV_SYSTEM: begin
        if (w[13:12] != 2'b00) begin
          s1 = w[14] ? core_pkg::IMM : core_pkg::REG_RF;
          it = core_pkg::CSR_IMM;
          use_imm = 1'b1;
          b.csr.op = core_pkg::csr_t'(w[14:12]);
          b.csr.addr = w[31:20];
          b.we_rd = (w[11:7] != 5'd0);
        end else if (w[14] || (w[11:7] != 5'd0) || (w[19:15] != 5'd0)) begin
          ill = 1'b1;
        end else begin
          case ({w[31:25], w[24:20]})
            {7'h00, 5'd0}: b.ecall = 1'b1;
            {7'h00, 5'd1}: begin
              b.ebreak = (SUPPORT_DEBUG != 0);
              ill = (SUPPORT_DEBUG == 0);
            end
            {7'h18, 5'd2}: b.mret = 1'b1;
            {7'h08, 5'd5}: b.wfi = 1'b1;
            default: ill = 1'b1;
          endcase
        end
      end
      default: ill = 1'b1;
    endcase
    b.rs1_op = s1;
    b.rs2_op = s2;
    if (use_imm) begin
      b.imm = core_pkg::gen_imm(w, it);
    end
    if (ill) begin
      b = '0;
    end
    b.pc_dec = pc;
    return b;
  endfunction

  function automatic core_pkg::instr_raw_t random_legal(input int k);
    logic [31:0] r;
    logic [31:0] w;
    r = $urandom;
    w = $urandom;
    case (k)
      0: w[6:0] = core_pkg::RV_LUI;
      1: w[6:0] = core_pkg::RV_AUIPC;
      2: w[6:0] = core_pkg::RV_JAL;
      3: begin
        w[6:0] = core_pkg::RV_JALR;
        w[14:12] = 3'b000;
      end
      4: begin
        w[6:0] = core_pkg::RV_OP;
        w[31:25] = {1'b0, r[0], 5'b00000};
      end
      5: begin
        w[6:0] = core_pkg::RV_BRANCH;
        // 010 and 011 are not branch conditions
        w[14] = w[14] | w[13];
      end
      6: begin
        w[6:0] = core_pkg::RV_LOAD;
        if ((w[14:12] == 3'b011) || (w[14:13] == 2'b11)) begin
          w[14:12] = 3'b010;
        end
      end
      7: begin
        w[6:0] = core_pkg::RV_STORE;
        w[14:12] = (r[2:1] == 2'b11) ? 3'b010 : {1'b0, r[2:1]};
      end
      8: begin
        w[6:0] = core_pkg::RV_OP_IMM;
        if (w[13:12] == 2'b01) begin
          w[31:25] = {1'b0, r[0] & w[14], 5'b00000};
        end
      end
      9: w[6:0] = core_pkg::RV_MISC_MEM;
      default: begin
        w[6:0] = core_pkg::RV_SYSTEM;
        if (r[0]) begin
          w[14:12] = {r[3], r[2:1] | {1'b0, r[2:1] == 2'b00}};
        end else begin
          w[14:12] = 3'b000;
          w[11:7] = 5'd0;
          w[19:15] = 5'd0;
          case (r[2:1])
            2'd0: w[31:20] = {7'h00, 5'd0};
            2'd1: w[31:20] = {7'h00, 5'd1};
            2'd2: w[31:20] = {7'h18, 5'd2};
            default: w[31:20] = {7'h08, 5'd5};
          endcase
        end
      end
    endcase
    return w;
  endfunction

  function automatic core_pkg::instr_raw_t random_illegal();
    logic [31:0] r;
    logic [31:0] w;
    r = $urandom;
    w = $urandom;
    case (r[1:0])
      // Every RV32I major opcode ends in 2'b11
      2'd0: w[1:0] = {w[1], 1'b0};
      2'd1: begin
        w[6:0] = core_pkg::RV_SYSTEM;
        w[14:12] = 3'b100;
      end
      2'd2: begin
        w[6:0] = core_pkg::RV_SYSTEM;
        w[14:12] = 3'b000;
        w[11:7] = w[11:7] | 5'd1;
      end
      default: begin
        w[6:0] = core_pkg::RV_SYSTEM;
        w[14:12] = 3'b000;
        w[11:7] = 5'd0;
        w[19:15] = 5'd0;
        w[31:25] = 7'h7f;
      end
    endcase
    return w;
  endfunction

  // One clock cycle: drive, check, then advance the model at the edge
  task automatic step(input logic valid, input core_pkg::instr_raw_t instr,
                      input logic ready, input logic jump, input core_pkg::pc_t pc_jump,
                      input core_pkg::s_wb_t wb);
    core_pkg::s_id_ex_t     b;
    core_pkg::s_trap_info_t t;
    logic                   ill;
    logic                   acc;
    fetch_valid_i = valid;
    fetch_instr_i = instr;
    id_ready_i = ready;
    jump_i = jump;
    pc_jump_i = pc_jump;
    wb_dec_i = wb;
    #10;
    acc = valid && ready;
    b = model_decode(instr, exp_pc, ill);
    t = '0;
    if (acc && ill) begin
      t.active = 1'b1;
      t.pc_addr = exp_pc;
    end
    check_val("fetch_ready_o", 128'(ready), 128'(fetch_ready_o));
    check_val("trap_info_o", 128'(t), 128'(trap_info_o));
    check_val("id_valid_o", 128'(exp_valid), 128'(id_valid_o));
    if (jump) begin
      check_val("id_ex_o", '0, 128'(id_ex_o));
    end else if (exp_valid) begin
      check_bundle(exp_bundle, id_ex_o);
    end
    if (exp_valid) begin
      check_val("rs1_data_o", 128'(exp_rs1), 128'(rs1_data_o));
      check_val("rs2_data_o", 128'(exp_rs2), 128'(rs2_data_o));
    end
    @(posedge clk);
    if (ready) begin
      exp_valid = valid;
      exp_bundle = b;
      exp_rs1 = regs[instr[19:15]];
      exp_rs2 = regs[instr[24:20]];
    end
    if (jump) begin
      exp_pc = pc_jump;
    end else if (acc) begin
      exp_pc = exp_pc + 32'd4;
    end
    if (wb.we_rd && (wb.rd_addr != 5'd0)) begin
      regs[wb.rd_addr] = wb.rd_data;
    end
    @(negedge clk);
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while ((id_valid_o !== 1'b1) && (n < TIMEOUT)) begin
      @(negedge clk);
      n++;
    end
    if (n >= TIMEOUT) begin
      err_cnt++;
      $display("timeout: id_valid_o did not rise within %0d cycles", TIMEOUT);
    end
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    core_pkg::instr_raw_t w;
    core_pkg::s_wb_t      wb;
    logic [31:0]          r;
    int                   n;
    void'($urandom(32'h6b2fa1d6));
    rst_i = 1'b1;
    jump_i = 1'b0;
    pc_jump_i = '0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    wb_dec_i = '0;
    id_ready_i = 1'b1;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    exp_pc = RESET_PC;
    exp_bundle = '0;
    exp_rs1 = '0;
    exp_rs2 = '0;
    exp_valid = 1'b0;
    err_cnt = 0;
    err_mark = 0;
    tests_ok = 0;
    tests_bad = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    for (int i = 0; i < 330; i++) begin
      step(1'b1, random_legal(i % 11), 1'b1, 1'b0, '0, '0);
      wait_valid();
    end
    step(1'b0, '0, 1'b1, 1'b0, '0, '0);
    finish_test("field_decode");

    // Fill every register, x0 included
    for (int i = 0; i < 32; i++) begin
      wb.rd_addr = i[4:0];
      wb.rd_data = $urandom;
      wb.we_rd = 1'b1;
      step(1'b0, '0, 1'b1, 1'b0, '0, wb);
    end
    for (int i = 0; i < 150; i++) begin
      w = random_legal(4);
      r = $urandom;
      wb.rd_addr = (i % 4 == 0) ? w[19:15] : r[4:0];
      wb.rd_data = $urandom;
      wb.we_rd = r[5] | (i % 4 == 0);
      step(1'b1, w, 1'b1, 1'b0, '0, wb);
    end
    step(1'b0, '0, 1'b1, 1'b0, '0, '0);
    finish_test("register_read");

    for (int i = 0; i < 120; i++) begin
      r = $urandom;
      if (r[2:0] == 3'd0) begin
        r = $urandom;
        step(1'b0, '0, 1'b1, 1'b1, {r[31:2], 2'b00}, '0);
      end else begin
        step(1'b1, random_legal(i % 11), 1'b1, 1'b0, '0, '0);
      end
    end
    step(1'b0, '0, 1'b1, 1'b0, '0, '0);
    finish_test("pc_and_jump");

    for (int i = 0; i < 40; i++) begin
      r = $urandom;
      n = 1 + int'(r[2:0]) % 5;
      for (int j = 0; j < n; j++) begin
        r = $urandom;
        step(r[0], random_legal(int'(r[7:4]) % 11), 1'b0, 1'b0, '0, '0);
      end
      r = $urandom;
      n = 1 + int'(r[1:0]);
      for (int j = 0; j < n; j++) begin
        r = $urandom;
        step(r[0] | r[1], random_legal(int'(r[7:4]) % 11), 1'b1, 1'b0, '0, '0);
      end
    end
    step(1'b0, '0, 1'b1, 1'b0, '0, '0);
    finish_test("back_pressure");

    for (int i = 0; i < 80; i++) begin
      step(1'b1, random_illegal(), 1'b1, 1'b0, '0, '0);
      step(1'b1, random_legal(i % 11), 1'b1, 1'b0, '0, '0);
    end
    step(1'b0, '0, 1'b1, 1'b0, '0, '0);
    finish_test("illegal_trap");

    $display("tests passed %0d failed %0d, total errors %0d", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- list.f
hw/core_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/decode_stage.sv
hw/decode_top.sv
tb/decode_tb.sv

//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
